//--- bench/gw_vectors.txt
// record: test number, packet length, then the packet bytes, then the reply bytes
// all values hex, a record of test number 00 ends the list
02 18
5a a5 00 01 12 34 56 78 00 00 00 01 de ad be ef 00 00 00 02 01 23 45 67
5a a5 00 01 12 34 56 78 00 00 00 01 de ad be ef 00 00 00 02 01 23 45 67
02 18
5a a5 00 02 9a bc de f0 10 00 00 01 00 00 00 00 10 00 00 02 00 00 00 00
5a a5 00 02 9a bc de f0 10 00 00 01 de ad be ef 10 00 00 02 01 23 45 67
// repeat word of count 3, then a write of three words from register 4
03 1c
5a a5 00 03 00 00 00 03 20 00 00 03 00 00 00 04
11 11 11 11 22 22 22 22 33 33 33 33
5a a5 00 03 00 00 00 03 20 00 00 03 00 00 00 04
11 11 11 11 22 22 22 22 33 33 33 33
03 1c
5a a5 00 04 00 00 00 04 20 00 00 03 10 00 00 04
00 00 00 00 00 00 00 00 00 00 00 00
5a a5 00 04 00 00 00 04 20 00 00 03 10 00 00 04
11 11 11 11 22 22 22 22 33 33 33 33
// address 0x11 lies above the bank and shares its low bits with register 1
04 20
5a a5 00 05 00 00 00 05 00 00 00 11 ff ff ff ff
10 00 00 11 aa aa aa aa 10 00 00 01 00 00 00 00
5a a5 00 05 00 00 00 05 00 00 00 11 ff ff ff ff
10 00 00 11 00 00 00 00 10 00 00 01 de ad be ef
// padding only, one read, and a control word with no data word
05 08
5a a5 00 06 00 00 00 06
5a a5 00 06 00 00 00 06
05 10
5a a5 00 07 00 00 00 07 10 00 00 02 00 00 00 00
5a a5 00 07 00 00 00 07 10 00 00 02 01 23 45 67
05 0c
5a a5 00 08 00 00 00 08 10 00 00 05
5a a5 00 08 00 00 00 08 10 00 00 05
00

//--- sim.f
+incdir+design
design/gw_wire_pkg.sv
design/gw_bus_pkg.sv
design/local_bus_if.sv
design/beat_delay.sv
design/mem_gateway.sv
design/reg_bank.sv
design/gw_top.sv
bench/gw_tb.sv

//--- bench/gw_tb.sv
/*
 * testbench of the memory gateway subsystem
 * plays the packets of the vector file into the stream port with random
 * idle gaps, collects every reply byte flagged by oactive and compares
 * the replies and the prefill pulses with the expected values
 */
`timescale 1ns/10ps

module gw_tb;

	localparam int VEC_DEPTH = 1024;
	// covers N_LAT plus the longest reply with a wide margin
	localparam int WAIT_LIMIT = 200;

	logic        clk;
	logic        rst_n;
	logic [10:0] len_c;
	logic [7:0]  idata;
	logic        raw_l;
	logic        raw_s;
	logic [7:0]  odata;
	logic        oactive;
	logic        prefill;

	logic [7:0] vec [VEC_DEPTH];
	logic [7:0] exp_q [$];
	logic [7:0] got_q [$];
	int         exp_len_q [$];
	int         got_len_q [$];
	int         run_len = 0;
	int         prefill_seen = 0;
	int         errors = 0;
	int         tests_run = 0;
	int         tests_failed = 0;

	gw_top u_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.len_c   (len_c),
		.idata   (idata),
		.raw_l   (raw_l),
		.raw_s   (raw_s),
		.odata   (odata),
		.oactive (oactive),
		.prefill (prefill)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// outputs are registered, so the falling edge sees them settled
	// a reply ends on the first cycle with oactive low
	always @(negedge clk) begin
		if (oactive) begin
			got_q.push_back(odata);
			run_len++;
		end else if (run_len != 0) begin
			got_len_q.push_back(run_len);
			run_len = 0;
		end
		if (prefill) begin
			prefill_seen++;
		end
	end

	function automatic string test_name(input int test_id);
		case (test_id)
			1: return "idle after reset";
			2: return "write then read back";
			3: return "burst write and burst read";
			4: return "address above the bank";
			5: return "back to back packets";
			default: return "unnamed";
		endcase
	endfunction

	task automatic report_test(input int test_id, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("test %0d (%s): ok", test_id, test_name(test_id));
		end else begin
			tests_failed++;
			$display("test %0d (%s): failed with %0d errors", test_id, test_name(test_id),
				errors - err_start);
		end
	endtask

	// one packet, raw_l and raw_s framing the bytes with no gap inside
	task automatic send_packet(input int base, input int len);
		int gap;
		gap = 2 + ($urandom % 8);
		repeat (gap) @(negedge clk);
		for (int i = 0; i < len; i++) begin
			@(negedge clk);
			raw_l = 1'b1;
			raw_s = 1'b1;
			len_c = 11'(len);
			idata = vec[base + i];
		end
		@(negedge clk);
		raw_l = 1'b0;
		raw_s = 1'b0;
		len_c = '0;
		idata = '0;
	endtask

	// waits for every reply of the test, then compares length and bytes
	task automatic finish_test(input int test_id, input int err_start,
		input int prefill_start);
		int         n;
		int         waited;
		int         got_len;
		int         exp_len;
		logic [7:0] exp_byte;
		logic [7:0] got_byte;
		n = exp_len_q.size();
		waited = 0;
		while (got_len_q.size() < n && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (got_len_q.size() < n) begin
			$display("test %0d: timed out with %0d of %0d replies seen on oactive",
				test_id, got_len_q.size(), n);
			errors++;
		end
		for (int p = 0; p < n; p++) begin
			exp_len = exp_len_q.pop_front();
			got_len = 0;
			if (got_len_q.size() != 0) begin
				got_len = got_len_q.pop_front();
			end
			if (got_len != exp_len) begin
				$display("Mismatch at %0t: oactive byte count expected %0d got %0d (test %0d pkt %0d)",
					$time, exp_len, got_len, test_id, p);
				errors++;
			end
			for (int i = 0; i < exp_len; i++) begin
				exp_byte = exp_q.pop_front();
				if (i < got_len) begin
					got_byte = got_q.pop_front();
					if (got_byte !== exp_byte) begin
						$display("Mismatch at %0t: odata expected %02h got %02h (test %0d.%0d byte %0d)",
							$time, exp_byte, got_byte, test_id, p, i);
						errors++;
					end
				end
			end
			for (int i = exp_len; i < got_len; i++) begin
				got_byte = got_q.pop_front();
			end
		end
		// a late or stray reply must not spill into the next test
		got_q.delete();
		got_len_q.delete();
		if (prefill_seen - prefill_start != n) begin
			$display("Mismatch at %0t: prefill pulse count expected %0d got %0d (test %0d)",
				$time, n, prefill_seen - prefill_start, test_id);
			errors++;
		end
		report_test(test_id, err_start);
	endtask

	initial begin : main_flow
		int pos;
		int test_id;
		int len;
		int cur_test;
		int test_err;
		int prefill_start;
		int seed;
		rst_n = 1'b0;
		len_c = '0;
		idata = '0;
		raw_l = 1'b0;
		raw_s = 1'b0;
		seed = 55972;
		void'($urandom(seed));
		$readmemh("bench/gw_vectors.txt", vec);
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// with no packet in sight both outputs must stay quiet
		test_err = errors;
		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			if (oactive !== 1'b0) begin
				$display("Mismatch at %0t: oactive expected 0 got %b", $time, oactive);
				errors++;
			end
			if (prefill !== 1'b0) begin
				$display("Mismatch at %0t: prefill expected 0 got %b", $time, prefill);
				errors++;
			end
		end
		report_test(1, test_err);

		// each record is test number, length, packet bytes, reply bytes
		pos = 0;
		cur_test = 0;
		prefill_start = 0;
		while (pos < VEC_DEPTH - 1 && vec[pos] !== 8'h00 && !$isunknown(vec[pos])) begin
			test_id = vec[pos];
			len = vec[pos + 1];
			if (test_id != cur_test) begin
				if (cur_test != 0) begin
					finish_test(cur_test, test_err, prefill_start);
				end
				cur_test = test_id;
				test_err = errors;
				prefill_start = prefill_seen;
			end
			exp_len_q.push_back(len);
			for (int i = 0; i < len; i++) begin
				exp_q.push_back(vec[pos + 2 + len + i]);
			end
			send_packet(pos + 2, len);
			pos = pos + 2 + 2 * len;
		end
		if (cur_test != 0) begin
			finish_test(cur_test, test_err, prefill_start);
		end else begin
			$display("no packets were read from the vector file");
			errors++;
		end

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- design/gw_top.sv
/*
 * memory gateway subsystem, the packet parser in front of a small
 * register bank, joined by one local bus
 */
`timescale 1ns/10ps

module gw_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [10:0] len_c,
	input  logic [7:0]  idata,
	input  logic        raw_l,
	input  logic        raw_s,
	output logic [7:0]  odata,
	output logic        oactive,
	output logic        prefill
);

	local_bus_if bus_if ();

	// stream side, drives the bus
	mem_gateway u_gateway (
		.clk     (clk),
		.rst_n   (rst_n),
		.len_c   (len_c),
		.idata   (idata),
		.raw_l   (raw_l),
		.raw_s   (raw_s),
		.odata   (odata),
		.oactive (oactive),
		.prefill (prefill),
		.bus     (bus_if.master)
	);

	// registers that answer reads and writes
	reg_bank u_bank (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (bus_if.target)
	);

endmodule

//--- design/reg_bank.sv
/*
 * register bank on the local bus
 * REG_WORDS words selected by the low address bits, anything above that
 * range reads zero and drops writes, read data comes back READ_PIPE_LEN
 * cycles after the strobe
 */
`timescale 1ns/10ps
`include "gw_config.svh"

module reg_bank (
	input  logic        clk,
	input  logic        rst_n,
	local_bus_if.target bus
);

	localparam int RPL = `READ_PIPE_LEN;
	localparam int IDX_W = $bits(gw_bus_pkg::reg_index_t);
	localparam int ADDR_W = $bits(gw_bus_pkg::bus_addr_t);

	gw_bus_pkg::bus_data_t  regs [`REG_WORDS];
	gw_bus_pkg::bus_data_t  rd_pipe [RPL];
	gw_bus_pkg::reg_index_t idx;
	logic                   in_range;

	assign idx = bus.addr[IDX_W-1:0];
	// every address bit above the index must be clear
	assign in_range = ~|bus.addr[ADDR_W-1:IDX_W];

	// writes land on the edge that samples the strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_WORDS; i++) begin
				regs[i] <= '0;
			end
		end else if (bus.write && in_range) begin
			regs[idx] <= bus.data_out;
		end
	end

	// the first stage samples the register at the strobe, the rest only wait
	always_ff @(posedge clk) begin
		if (bus.strobe && bus.rd && in_range) begin
			rd_pipe[0] <= regs[idx];
		end else begin
			rd_pipe[0] <= '0;
		end
		for (int i = 1; i < RPL; i++) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
	end

	// last stage lines up with rd_valid from the gateway
	assign bus.data_in = rd_pipe[RPL-1];

endmodule

//--- design/mem_gateway.sv
/*
 * UDP payload to local bus gateway
 * skips the padding, splits the rest into control and data words, issues
 * one bus operation per data word (more with a repeat word) and sends
 * the stream back N_LAT cycles later with read data spliced in
 */
`timescale 1ns/10ps
`include "gw_config.svh"

module mem_gateway (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [10:0]             len_c,
	input  gw_wire_pkg::wire_byte_t idata,
	input  logic                    raw_l,
	input  logic                    raw_s,
	output gw_wire_pkg::wire_byte_t odata,
	output logic                    oactive,
	output logic                    prefill,
	local_bus_if.master             bus
);

	localparam int RPL = `READ_PIPE_LEN;
	localparam int PAD_WORDS = gw_wire_pkg::pad_bytes / 4;
	localparam int PAD_W = $clog2(PAD_WORDS + 1);
	// the first reply byte reaches the osr output this many cycles after sof
	localparam int LEAD = RPL + 4;
	localparam int LEAD_W = $clog2(LEAD + 1);
	localparam logic BURSTS = (`ENABLE_BURSTS != 0);

	gw_wire_pkg::wire_byte_t pdata;
	gw_wire_pkg::tx_beat_t   xbeat;
	gw_wire_pkg::tx_beat_t   obeat;
	gw_wire_pkg::ctrl_word_t next_ctrl;
	gw_wire_pkg::ctrl_word_t ctrl_r;
	gw_bus_pkg::bus_data_t   data_r;
	gw_bus_pkg::bus_data_t   osr;
	logic [31:0]             next_isr;
	logic [23:0]             isr;
	logic [1:0]              c4;
	logic [PAD_W-1:0]        pad_cnt;
	logic [gw_wire_pkg::repeat_bits-1:0] repeat_count;
	logic                    body;
	logic                    data_phase;
	logic                    inc_address;
	logic                    do_op;
	logic                    word_done;
	logic                    op_word;
	logic                    set_repeat;
	logic                    read_op;
	logic [RPL-1:0]          rd_marks;
	logic                    raw_s_r;
	logic                    raw_l_r;
	logic [10:0]             len_r;
	logic [LEAD_W-1:0]       lead_cnt;
	logic [10:0]             tx_left;

	// input bytes wait here while the word around them is being read
	beat_delay #(
		.beat_t (gw_wire_pkg::wire_byte_t),
		.length (RPL + 1)
	) u_align (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (idata),
		.dout  (pdata)
	);

	// big-endian word assembly, the newest byte is the low byte
	assign next_isr = {isr, idata};
	assign next_ctrl = gw_wire_pkg::ctrl_word_t'(next_isr);
	assign word_done = raw_s & (&c4);
	assign op_word = body & word_done;
	// a repeat word only counts where a control word is expected
	assign set_repeat = ~data_phase & next_ctrl.repeat_flag & BURSTS;

	// parser state, dropping raw_s returns it to the padding
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			c4 <= 2'd0;
			pad_cnt <= '0;
			body <= 1'b0;
			data_phase <= 1'b0;
			repeat_count <= '0;
			inc_address <= 1'b0;
			do_op <= 1'b0;
		end else begin
			c4 <= raw_s ? c4 + 2'd1 : 2'd0;
			if (!raw_s) begin
				pad_cnt <= '0;
				body <= 1'b0;
				data_phase <= 1'b0;
				repeat_count <= '0;
				inc_address <= 1'b0;
			end else if (word_done && !body) begin
				if (pad_cnt == PAD_W'(PAD_WORDS - 1)) begin
					body <= 1'b1;
				end else begin
					pad_cnt <= pad_cnt + 1'b1;
				end
			end else if (op_word) begin
				inc_address <= 1'b0;
				if (set_repeat) begin
					// the count includes the first operation
					repeat_count <= next_ctrl.addr[gw_wire_pkg::repeat_bits-1:0] - 1'b1;
				end else if (!data_phase) begin
					data_phase <= 1'b1;
				end else if (|repeat_count) begin
					// stay in the data phase and step the address next word
					repeat_count <= repeat_count - 1'b1;
					inc_address <= 1'b1;
				end else begin
					data_phase <= 1'b0;
				end
			end
			do_op <= op_word & data_phase;
		end
	end

	// control and data words of the current operation
	always_ff @(posedge clk) begin
		isr <= next_isr[23:0];
		if (op_word) begin
			if (!data_phase && !set_repeat) begin
				ctrl_r <= next_ctrl;
			end else if (data_phase) begin
				data_r <= next_isr;
			end
			if (inc_address) begin
				ctrl_r.addr <= ctrl_r.addr + 1'b1;
			end
		end
	end

	assign bus.addr = ctrl_r.addr;
	assign bus.data_out = data_r;
	assign bus.rd = ctrl_r.read_flag;
	assign bus.strobe = do_op;
	assign bus.write = do_op & ~ctrl_r.read_flag;

	// every read in flight leaves a marker that arrives with its data
	assign read_op = do_op & ctrl_r.read_flag;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_marks <= '0;
		end else begin
			rd_marks[0] <= read_op;
			for (int i = 1; i < RPL; i++) begin
				rd_marks[i] <= rd_marks[i-1];
			end
		end
	end

	assign bus.rd_valid = rd_marks[RPL-1];

	// the read result replaces exactly the four echoed data bytes
	always_ff @(posedge clk) begin
		if (bus.rd_valid) begin
			osr <= bus.data_in;
		end else begin
			osr <= {osr[23:0], pdata};
		end
	end

	// reply framing, len_c bytes starting LEAD+1 cycles after the first byte
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			raw_s_r <= 1'b0;
			len_r <= '0;
			lead_cnt <= '0;
			tx_left <= '0;
		end else begin
			raw_s_r <= raw_s;
			if (raw_s && !raw_s_r) begin
				len_r <= len_c;
				lead_cnt <= LEAD_W'(LEAD);
			end else if (|lead_cnt) begin
				lead_cnt <= lead_cnt - 1'b1;
			end
			if (lead_cnt == LEAD_W'(1)) begin
				tx_left <= len_r;
			end else if (|tx_left) begin
				tx_left <= tx_left - 1'b1;
			end
		end
	end

	assign xbeat.active = |tx_left;
	// idle cycles send zero instead of whatever is left in osr
	assign xbeat.data = xbeat.active ? osr[31:24] : '0;

	// line up with the other clients of the packet engine
	beat_delay #(
		.beat_t (gw_wire_pkg::tx_beat_t),
		.length (`N_LAT - RPL - 5)
	) u_finale (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (xbeat),
		.dout  (obeat)
	);

	assign odata = obeat.data;
	assign oactive = obeat.active;

	// one pulse on the rising edge of raw_l
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			raw_l_r <= 1'b0;
			prefill <= 1'b0;
		end else begin
			raw_l_r <= raw_l;
			prefill <= raw_l & ~raw_l_r;
		end
	end

endmodule

//--- design/beat_delay.sv
/*
 * fixed delay line of registers, the payload type is a parameter so the
 * same chain carries raw stream bytes and flagged reply beats
 */
`timescale 1ns/10ps

module beat_delay #(
	parameter type beat_t = logic [7:0],
	parameter int  length = 1
) (
	input  logic  clk,
	input  logic  rst_n,
	input  beat_t din,
	output beat_t dout
);

	generate
		if (length == 0) begin : g_pass
			// a zero length only shows up when N_LAT sits at its minimum
			assign dout = din;
		end else begin : g_chain
			beat_t stage [length];

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					for (int i = 0; i < length; i++) begin
						stage[i] <= '0;
					end
				end else begin
					stage[0] <= din;
					for (int i = 1; i < length; i++) begin
						stage[i] <= stage[i-1];
					end
				end
			end

			assign dout = stage[length-1];
		end
	endgenerate

endmodule

//--- design/local_bus_if.sv
/*
 * local register bus between gateway and register bank
 * strobe pulses once per operation, addr, data_out and rd are levels
 * that hold until the next operation, and rd_valid marks the cycle in
 * which the target must present read data on data_in
 */
`timescale 1ns/10ps

interface local_bus_if;

	gw_bus_pkg::bus_addr_t addr;
	gw_bus_pkg::bus_data_t data_out;
	gw_bus_pkg::bus_data_t data_in;
	logic                  rd;
	logic                  strobe;
	logic                  write;
	logic                  rd_valid;

	// the gateway owns the bus and reads back rd_valid for its own capture
	modport master (
		output addr,
		output data_out,
		output rd,
		output strobe,
		output write,
		output rd_valid,
		input  data_in
	);

	// the register bank only answers
	modport target (
		input  addr,
		input  data_out,
		input  rd,
		input  strobe,
		input  write,
		output data_in
	);

endinterface

//--- design/gw_bus_pkg.sv
/*
 * types of the local register bus behind the gateway: address and data
 * words, and the index into the register bank
 */
`include "gw_config.svh"

package gw_bus_pkg;

	// the bus keeps the 24-bit address of the control word
	typedef logic [23:0] bus_addr_t;

	// all transfers are full 32-bit words
	typedef logic [31:0] bus_data_t;

	// enough bits to select one register of the bank, 4 for 16 words
	typedef logic [$clog2(`REG_WORDS)-1:0] reg_index_t;

endpackage

//--- design/gw_wire_pkg.sv
/*
 * on-the-wire formats of the memory gateway: the big-endian control word
 * that precedes each data word, and the reply beat sent back to the host
 */
package gw_wire_pkg;

	// one byte of the client stream
	typedef logic [7:0] wire_byte_t;

	// bytes of sequence number or nonce ahead of the first operation
	localparam int pad_bytes = 8;

	// a repeat word carries its count in the low bits of the address field
	localparam int repeat_bits = 9;

	// control word, the first half of every 8-byte operation
	typedef struct packed {
		logic [1:0]  spare;
		logic        repeat_flag;
		logic        read_flag;
		logic [3:0]  rsvd;
		logic [23:0] addr;
	} ctrl_word_t;

	// reply byte, active marks the bytes that belong to a packet
	typedef struct packed {
		logic       active;
		wire_byte_t data;
	} tx_beat_t;

endpackage

//--- design/gw_config.svh
/*
 * build-time settings of the UDP memory gateway: read latency on the
 * local bus, total packet turnaround, burst support and the size of
 * the register bank
 */
`ifndef GW_CONFIG_SVH
`define GW_CONFIG_SVH

// cycles from a read strobe to the capture of data_in, at least 1
`define READ_PIPE_LEN 4

// cycles from an input byte to its reply byte, at least READ_PIPE_LEN+5
`define N_LAT 9

// set to 1 to accept repeat words that start an auto-increment burst
`define ENABLE_BURSTS 1

// number of 32-bit words in the register bank
`define REG_WORDS 16

`endif
